/* src/cache_cfg_pkg.sv */
/*
 * L2 cache geometry. Line, set and way sizes and the vector
 * types that carry these widths through the pipeline
 */

`default_nettype none

package cache_cfg_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Geometry
	////////////////////////////////////////////////////////////////////////////

	localparam int LINE_BYTES = 16;                 // Bytes per line
	localparam int LINE_BITS  = LINE_BYTES * 8;     // 128-bit line
	localparam int NUM_SETS   = 16;
	localparam int NUM_WAYS   = 4;
	localparam int SET_BITS   = 4;                  // log2(NUM_SETS)
	localparam int WAY_BITS   = 2;                  // log2(NUM_WAYS)
	localparam int ADDR_BITS  = 26;                 // Line address, no byte offset
	localparam int TAG_BITS   = ADDR_BITS - SET_BITS;

	////////////////////////////////////////////////////////////////////////////
	// Derived vector types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [LINE_BITS-1:0]  line_t;
	typedef logic [LINE_BYTES-1:0] byte_mask_t;     // One enable per byte
	typedef logic [SET_BITS-1:0]   set_idx_t;
	typedef logic [WAY_BITS-1:0]   way_t;
	typedef logic [TAG_BITS-1:0]   cache_tag_t;
	typedef logic [ADDR_BITS-1:0]  line_addr_t;     // {tag, set}

	// Requester identity, echoed back in every response
	typedef logic [1:0] unit_id_t;
	typedef logic [1:0] strand_id_t;                // Thread within a unit

endpackage

`default_nettype wire

/* src/cache_msg_pkg.sv */
/*
 * L2 cache messages. Request and response formats and the
 * stage-to-stage and array-write records of the pipeline
 */

`default_nettype none

package cache_msg_pkg;

	import cache_cfg_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Requester interface
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0]
	{
		OP_LOAD  = 3'd0,
		OP_STORE = 3'd1,
		OP_FILL  = 3'd2                                 // Install a line from outside
	} pci_op_e;

	typedef struct packed
	{
		unit_id_t   unit;
		strand_id_t strand;
		pci_op_e    op;
		line_addr_t addr;
		line_t      data;                               // Store or fill data
		byte_mask_t mask;                               // Store byte enables
	} pci_req_t;

	typedef struct packed
	{
		logic       status;                             // Hit flag
		unit_id_t   unit;
		strand_id_t strand;
		pci_op_e    op;
		way_t       way;
		line_t      data;
	} cpi_rsp_t;

	////////////////////////////////////////////////////////////////////////////
	// Internal pipeline records
	////////////////////////////////////////////////////////////////////////////

	// Tag lookup result handed to the merge stage
	typedef struct packed
	{
		pci_req_t req;
		logic     hit;
		way_t     hit_way;
		way_t     victim_way;                           // Round-robin choice
	} lookup_t;

	typedef struct packed
	{
		logic     en;
		set_idx_t set_idx;
		way_t     way;
		line_t    line;
	} line_write_t;

	typedef struct packed
	{
		logic       en;
		set_idx_t   set_idx;
		way_t       way;
		cache_tag_t tag;
	} tag_write_t;

endpackage

`default_nettype wire

/* src/l2_tag_lookup.sv */
/*
 * L2 tag lookup. Compares the request tag against all ways of
 * its set, picks the round-robin victim and forwards the request
 */

`default_nettype none

module l2_tag_lookup
(
	input  logic                      clk,
	input  logic                      rst_i,
	input  logic                      pci_valid_i,
	input  cache_msg_pkg::pci_req_t   pci_i,
	input  cache_msg_pkg::tag_write_t tag_wr_i,
	output logic                      lookup_valid_o,
	output cache_msg_pkg::lookup_t    lookup_o
);

	import cache_cfg_pkg::*;
	import cache_msg_pkg::*;

	cache_tag_t          tag_mem [NUM_SETS][NUM_WAYS];
	logic [NUM_WAYS-1:0] valid_mem [NUM_SETS];
	way_t                rr_ptr [NUM_SETS];             // Next victim per set

	set_idx_t            req_set;
	cache_tag_t          req_tag;
	logic                wr_same_set;
	cache_tag_t          rd_tag [NUM_WAYS];
	logic [NUM_WAYS-1:0] rd_valid;
	way_t                rd_ptr;
	logic                hit;
	way_t                hit_way;

	assign req_set     = pci_i.addr[SET_BITS-1:0];
	assign req_tag     = pci_i.addr[ADDR_BITS-1:SET_BITS];
	assign wr_same_set = tag_wr_i.en && (tag_wr_i.set_idx == req_set);

	////////////////////////////////////////////////////////////////////////////
	// Set read with bypass of the write retiring this cycle
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			rd_tag[w]   = tag_mem[req_set][w];
			rd_valid[w] = valid_mem[req_set][w];
			if (wr_same_set && tag_wr_i.way == way_t'(w))
			begin
				rd_tag[w]   = tag_wr_i.tag;             // Line being installed
				rd_valid[w] = 1'b1;
			end
		end

		// Every tag write lands on the victim, so the pointer moves past it
		rd_ptr = wr_same_set ? tag_wr_i.way + 1'b1 : rr_ptr[req_set];
	end

	// At most one way can hold a given tag
	always_comb
	begin
		hit     = 1'b0;
		hit_way = '0;
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			if (rd_valid[w] && rd_tag[w] == req_tag)
			begin
				hit     = 1'b1;
				hit_way = way_t'(w);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Storage update and stage register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			lookup_valid_o <= 1'b0;
			for (int s = 0; s < NUM_SETS; s++)
			begin
				valid_mem[s] <= '0;                     // All lines invalid
				rr_ptr[s]    <= '0;
			end
		end
		else
		begin
			lookup_valid_o <= pci_valid_i;
			if (tag_wr_i.en)
			begin
				valid_mem[tag_wr_i.set_idx][tag_wr_i.way] <= 1'b1;
				rr_ptr[tag_wr_i.set_idx] <= tag_wr_i.way + 1'b1;  // Wraps mod 4
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (tag_wr_i.en)
			tag_mem[tag_wr_i.set_idx][tag_wr_i.way] <= tag_wr_i.tag;

		lookup_o.req        <= pci_i;
		lookup_o.hit        <= hit;
		lookup_o.hit_way    <= hit_way;
		lookup_o.victim_way <= rd_ptr;
	end

endmodule

`default_nettype wire

/* src/l2_data_array.sv */
/*
 * L2 line storage. Reads all ways of the requested set in one
 * cycle and applies line writes from the merge stage
 */

`default_nettype none

module l2_data_array
(
	input  logic                                      clk,
	input  cache_msg_pkg::pci_req_t                   pci_i,
	input  cache_msg_pkg::line_write_t                line_wr_i,
	output cache_cfg_pkg::line_t [cache_cfg_pkg::NUM_WAYS-1:0] set_lines_o
);

	import cache_cfg_pkg::*;
	import cache_msg_pkg::*;

	line_t                 line_mem [NUM_SETS][NUM_WAYS];   // 64 lines
	set_idx_t              rd_set;
	logic                  wr_same_set;
	line_t [NUM_WAYS-1:0]  rd_lines;

	assign rd_set      = pci_i.addr[SET_BITS-1:0];
	assign wr_same_set = line_wr_i.en && (line_wr_i.set_idx == rd_set);

	////////////////////////////////////////////////////////////////////////////
	// Read port
	////////////////////////////////////////////////////////////////////////////

	// A store or fill retiring now must be visible to the request behind it
	always_comb
	begin
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			if (wr_same_set && line_wr_i.way == way_t'(w))
				rd_lines[w] = line_wr_i.line;           // Bypass
			else
				rd_lines[w] = line_mem[rd_set][w];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Write port and output register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (line_wr_i.en)
			line_mem[line_wr_i.set_idx][line_wr_i.way] <= line_wr_i.line;

		set_lines_o <= rd_lines;
	end

endmodule

`default_nettype wire

/* src/l2_line_merge.sv */
/*
 * L2 line merge. Selects the hit line, merges store bytes, issues
 * the line and tag writes and registers the response
 */

`default_nettype none

module l2_line_merge
(
	input  logic                                      clk,
	input  logic                                      rst_i,
	input  logic                                      lookup_valid_i,
	input  cache_msg_pkg::lookup_t                    lookup_i,
	input  cache_cfg_pkg::line_t [cache_cfg_pkg::NUM_WAYS-1:0] set_lines_i,
	output cache_msg_pkg::line_write_t                line_wr_o,
	output cache_msg_pkg::tag_write_t                 tag_wr_o,
	output logic                                      cpi_valid_o,
	output cache_msg_pkg::cpi_rsp_t                   cpi_o
);

	import cache_cfg_pkg::*;
	import cache_msg_pkg::*;

	pci_req_t req;
	line_t    hit_line;
	line_t    merged_line;
	cpi_rsp_t rsp;

	assign req      = lookup_i.req;
	assign hit_line = set_lines_i[lookup_i.hit_way];

	// Masked bytes from the store, the rest from the cached line
	always_comb
	begin
		for (int b = 0; b < LINE_BYTES; b++)
			merged_line[b*8 +: 8] = req.mask[b] ? req.data[b*8 +: 8] : hit_line[b*8 +: 8];
	end

	////////////////////////////////////////////////////////////////////////////
	// Op decode
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		line_wr_o.en      = 1'b0;
		line_wr_o.set_idx = req.addr[SET_BITS-1:0];
		line_wr_o.way     = lookup_i.hit_way;
		line_wr_o.line    = merged_line;

		tag_wr_o.en       = 1'b0;
		tag_wr_o.set_idx  = req.addr[SET_BITS-1:0];
		tag_wr_o.way      = lookup_i.victim_way;
		tag_wr_o.tag      = req.addr[ADDR_BITS-1:SET_BITS];

		rsp.status        = 1'b0;                       // Miss unless decided otherwise
		rsp.unit          = req.unit;
		rsp.strand        = req.strand;
		rsp.op            = req.op;
		rsp.way           = '0;
		rsp.data          = '0;

		case (req.op)
			OP_LOAD:
			begin
				if (lookup_i.hit)
				begin
					rsp.status = 1'b1;
					rsp.way    = lookup_i.hit_way;
					rsp.data   = hit_line;
				end
			end

			OP_STORE:
			begin
				if (lookup_i.hit)
				begin
					line_wr_o.en = lookup_valid_i;
					rsp.status   = 1'b1;
					rsp.way      = lookup_i.hit_way;
					rsp.data     = merged_line;
				end
			end

			OP_FILL:
			begin
				line_wr_o.en   = lookup_valid_i;
				line_wr_o.line = req.data;
				if (!lookup_i.hit)
				begin
					line_wr_o.way = lookup_i.victim_way;
					tag_wr_o.en   = lookup_valid_i;     // New tag into the victim
				end
				rsp.status = lookup_i.hit;
				rsp.way    = line_wr_o.way;
				rsp.data   = req.data;
			end

			default:
			begin
				rsp.status = 1'b0;                      // Unknown op answers as a miss
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Response register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst_i)
			cpi_valid_o <= 1'b0;
		else
			cpi_valid_o <= lookup_valid_i;
	end

	always_ff @(posedge clk)
	begin
		cpi_o <= rsp;
	end

endmodule

`default_nettype wire

/* src/l2_cache.sv */
/*
 * Level 2 cache. Tag lookup and line read run side by side on
 * each request; the merge stage answers two cycles later
 */

`default_nettype none

module l2_cache
(
	input  logic                    clk,
	input  logic                    rst_i,
	input  logic                    pci_valid_i,
	input  cache_msg_pkg::pci_req_t pci_i,
	output logic                    cpi_valid_o,
	output cache_msg_pkg::cpi_rsp_t cpi_o
);

	import cache_cfg_pkg::*;
	import cache_msg_pkg::*;

	logic                 lookup_valid;
	lookup_t              lookup;
	line_t [NUM_WAYS-1:0] set_lines;                    // All ways of the set
	line_write_t          line_wr;
	tag_write_t           tag_wr;

	////////////////////////////////////////////////////////////////////////////
	// Stage 1 lookup
	////////////////////////////////////////////////////////////////////////////

	l2_tag_lookup u_tag_lookup
	(
		.clk            (clk),
		.rst_i          (rst_i),
		.pci_valid_i    (pci_valid_i),
		.pci_i          (pci_i),
		.tag_wr_i       (tag_wr),
		.lookup_valid_o (lookup_valid),
		.lookup_o       (lookup)
	);

	l2_data_array u_data_array
	(
		.clk         (clk),
		.pci_i       (pci_i),
		.line_wr_i   (line_wr),
		.set_lines_o (set_lines)
	);

	////////////////////////////////////////////////////////////////////////////
	// Stage 2 merge and response
	////////////////////////////////////////////////////////////////////////////

	l2_line_merge u_line_merge
	(
		.clk            (clk),
		.rst_i          (rst_i),
		.lookup_valid_i (lookup_valid),
		.lookup_i       (lookup),
		.set_lines_i    (set_lines),
		.line_wr_o      (line_wr),
		.tag_wr_o       (tag_wr),
		.cpi_valid_o    (cpi_valid_o),
		.cpi_o          (cpi_o)
	);

endmodule

`default_nettype wire

/* tests/l2_cache_model.svh */
/*
 * Reference model of the L2 cache. Tags, valid bits, lines and
 * round-robin pointers per set, and the expected response per request
 */

`ifndef L2_CACHE_MODEL_SVH
`define L2_CACHE_MODEL_SVH

cache_tag_t model_tag [NUM_SETS][NUM_WAYS];
logic       model_valid [NUM_SETS][NUM_WAYS];
line_t      model_line [NUM_SETS][NUM_WAYS];
way_t       model_ptr [NUM_SETS];                   // Next victim per set

task automatic clear_model();
	for (int s = 0; s < NUM_SETS; s++)
	begin
		model_ptr[s] = '0;
		for (int w = 0; w < NUM_WAYS; w++)
			model_valid[s][w] = 1'b0;
	end
endtask

// Applies one request to the model state and returns the response it must give
function automatic cpi_rsp_t reference_response(input pci_req_t req);
	cpi_rsp_t   rsp;
	set_idx_t   set_idx;
	cache_tag_t tag;
	logic       hit;
	way_t       way;
	line_t      line;

	set_idx = req.addr[SET_BITS-1:0];
	tag     = req.addr[ADDR_BITS-1:SET_BITS];
	hit     = 1'b0;
	way     = '0;
	for (int w = 0; w < NUM_WAYS; w++)
	begin
		if (model_valid[set_idx][w] && model_tag[set_idx][w] == tag)
		begin
			hit = 1'b1;
			way = way_t'(w);
		end
	end

	rsp.status = 1'b0;                              // Misses answer with zeros
	rsp.unit   = req.unit;
	rsp.strand = req.strand;
	rsp.op     = req.op;
	rsp.way    = '0;
	rsp.data   = '0;

	if (req.op == OP_LOAD && hit)
	begin
		rsp.status = 1'b1;
		rsp.way    = way;
		rsp.data   = model_line[set_idx][way];
	end
	else if (req.op == OP_STORE && hit)
	begin
		line = model_line[set_idx][way];
		for (int b = 0; b < LINE_BYTES; b++)
			if (req.mask[b])
				line[b*8 +: 8] = req.data[b*8 +: 8];
		model_line[set_idx][way] = line;
		rsp.status = 1'b1;
		rsp.way    = way;
		rsp.data   = line;
	end
	else if (req.op == OP_FILL)
	begin
		if (!hit)
		begin
			way                     = model_ptr[set_idx];   // Round-robin victim
			model_tag[set_idx][way] = tag;
			model_valid[set_idx][way] = 1'b1;
			model_ptr[set_idx]      = way + 1'b1;
		end
		model_line[set_idx][way] = req.data;
		rsp.status = hit;
		rsp.way    = way;
		rsp.data   = req.data;
	end
	return rsp;
endfunction

`endif

/* tests/l2_cache_tb.sv */
/*
 * Testbench for the L2 cache. Drives loads, stores and fills and
 * checks every response against the reference model
 */

`default_nettype none

module l2_cache_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import cache_cfg_pkg::*;
	import cache_msg_pkg::*;

	localparam int CLK_HALF    = 20;                // 40 ns period
	localparam int RST_CYCLES  = 8;
	localparam int MIX_REQS    = 300;
	localparam int TOTAL_REQS  = 6 + 6 + 7 + 10 + MIX_REQS;
	localparam int DRAIN_MAX   = 8;                 // Cycles to wait for the last response
	localparam int RSP_LATENCY = 2;                 // Issue edge to response edge

	logic     clk = 1'b0;
	logic     rst_i;
	logic     pci_valid_i;
	pci_req_t pci_i;
	logic     cpi_valid_o;
	cpi_rsp_t cpi_o;

	integer   seed = 32'h944d_71b4;
	cpi_rsp_t expected_q[$];
	string    name_q[$];
	int       issue_cycle_q[$];
	string    test_name;
	cpi_rsp_t chk_rsp;
	string    chk_name;
	int       chk_issue;
	int       cycle_count = 0;
	int       error_count = 0;
	int       errors_at_start;
	int       tests_run = 0;
	int       tests_failed = 0;

	`include "l2_cache_model.svh"

	l2_cache DUT
	(
		.clk         (clk),
		.rst_i       (rst_i),
		.pci_valid_i (pci_valid_i),
		.pci_i       (pci_i),
		.cpi_valid_o (cpi_valid_o),
		.cpi_o       (cpi_o)
	);

	always #CLK_HALF clk = ~clk;

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic line_t random_line();
		line_t line;
		for (int i = 0; i < LINE_BITS / 32; i++)
			line[i*32 +: 32] = $random(seed);
		return line;
	endfunction

	function automatic line_addr_t make_addr(input cache_tag_t tag, input set_idx_t set_idx);
		return {tag, set_idx};
	endfunction

	// One request per call, so back-to-back calls issue on consecutive cycles
	task automatic issue(input pci_op_e op, input line_addr_t addr, input line_t data,
		input byte_mask_t mask);
		pci_req_t req;
		req.unit   = unit_id_t'($random(seed));
		req.strand = strand_id_t'($random(seed));
		req.op     = op;
		req.addr   = addr;
		req.data   = data;
		req.mask   = mask;
		@(posedge clk);
		#2;
		pci_valid_i = 1'b1;
		pci_i       = req;
		expected_q.push_back(reference_response(req));
		name_q.push_back(test_name);
		issue_cycle_q.push_back(cycle_count);
	endtask

	task automatic start_test(input string name);
		test_name       = name;
		errors_at_start = error_count;
	endtask

	task automatic finish_test();
		int waited;
		@(posedge clk);
		#2;
		pci_valid_i = 1'b0;
		waited      = 0;
		while (expected_q.size() != 0 && waited < DRAIN_MAX)
		begin
			@(negedge clk);
			waited++;
		end
		if (expected_q.size() != 0)
		begin
			$display("%s: %0d responses never arrived", test_name, expected_q.size());
			error_count += expected_q.size();
			expected_q.delete();
			name_q.delete();
			issue_cycle_q.delete();
		end
		tests_run++;
		if (error_count != errors_at_start)
			tests_failed++;
		$display("test %s finished with %0d errors", test_name, error_count - errors_at_start);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Response checker
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		if (!rst_i && cpi_valid_o)
		begin
			if (expected_q.size() == 0)
			begin
				$display("a response arrived with no request pending at %0t", $time);
				error_count++;
			end
			else
			begin
				chk_rsp   = expected_q.pop_front();
				chk_name  = name_q.pop_front();
				chk_issue = issue_cycle_q.pop_front();
				if (cpi_o !== chk_rsp)
				begin
					$display("error %s: expected %h, actual %h", chk_name, chk_rsp, cpi_o);
					error_count++;
				end
				if (cycle_count - chk_issue != RSP_LATENCY)
				begin
					$display("error %s: latency expected %0d, actual %0d", chk_name,
						RSP_LATENCY, cycle_count - chk_issue);
					error_count++;
				end
			end
		end
	end

	// Watchdog sized from the request count
	initial
	begin
		repeat (TOTAL_REQS * 4 + 50) @(posedge clk);
		$display("timeout: the tests did not finish in the expected time");
		$display("Some tests failed");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		cache_tag_t tag_a;
		cache_tag_t tag_c;
		int         r;

		rst_i       = 1'b1;
		pci_valid_i = 1'b0;
		pci_i       = '0;
		test_name   = "reset";
		clear_model();
		repeat (RST_CYCLES) @(posedge clk);
		#2;
		rst_i = 1'b0;

		start_test("loads_after_reset");
		for (int i = 0; i < 6; i++)
			issue(OP_LOAD, line_addr_t'($random(seed)), random_line(), '0);
		finish_test();

		start_test("fill_then_load");
		for (int i = 1; i <= 3; i++)
		begin
			tag_a = cache_tag_t'($random(seed));
			issue(OP_FILL, make_addr(tag_a, set_idx_t'(i)), random_line(), '0);
			issue(OP_LOAD, make_addr(tag_a, set_idx_t'(i)), random_line(), '0);
		end
		finish_test();

		start_test("store_merge");
		tag_a = cache_tag_t'($random(seed));
		tag_c = tag_a ^ 22'h1;                      // Same set but another tag
		issue(OP_FILL, make_addr(tag_a, 4'd5), random_line(), '0);
		issue(OP_STORE, make_addr(tag_a, 4'd5), random_line(), byte_mask_t'($random(seed)));
		issue(OP_STORE, make_addr(tag_a, 4'd5), random_line(), byte_mask_t'($random(seed)));
		issue(OP_LOAD, make_addr(tag_a, 4'd5), random_line(), '0);
		issue(OP_STORE, make_addr(tag_c, 4'd5), random_line(), '1);
		issue(OP_LOAD, make_addr(tag_a, 4'd5), random_line(), '0);
		issue(OP_LOAD, make_addr(tag_c, 4'd5), random_line(), '0);
		finish_test();

		start_test("round_robin");
		for (int i = 0; i < 5; i++)
			issue(OP_FILL, make_addr(cache_tag_t'(100 + i), 4'd9), random_line(), '0);
		for (int i = 0; i < 5; i++)
			issue(OP_LOAD, make_addr(cache_tag_t'(100 + i), 4'd9), random_line(), '0);
		finish_test();

		start_test("random_mix");
		for (int i = 0; i < MIX_REQS; i++)
		begin
			r = $unsigned($random(seed)) % 3;
			issue(pci_op_e'(r),
				make_addr(cache_tag_t'($unsigned($random(seed)) % 4),
					set_idx_t'($unsigned($random(seed)) % 4)),
				random_line(), byte_mask_t'($random(seed)));
		end
		finish_test();

		$display("tests run: %0d, tests failed: %0d, errors: %0d",
			tests_run, tests_failed, error_count);
		if (error_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+tests
src/cache_cfg_pkg.sv
src/cache_msg_pkg.sv
src/l2_tag_lookup.sv
src/l2_data_array.sv
src/l2_line_merge.sv
src/l2_cache.sv
tests/l2_cache_tb.sv

/* Bender.yml */
package:
  name: l2_cache

sources:
  - files:
      - src/cache_cfg_pkg.sv
      - src/cache_msg_pkg.sv
      - src/l2_tag_lookup.sv
      - src/l2_data_array.sv
      - src/l2_line_merge.sv
      - src/l2_cache.sv

  - target: test
    include_dirs:
      - tests
    files:
      - tests/l2_cache_tb.sv
